// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator, run it and check the log"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert --top-module cart_bus_tb -f files.f -o cart_bus_sim
	./obj_dir/cart_bus_sim | tee sim.log
	grep -q "^PASS: all tests$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== cart_bus.sv ====
`timescale 1ns/1ps
`default_nettype none

module cart_bus import cart_pkg::*; (
	input  logic                    mclk,
	input  logic                    reset,

	input  logic [data_w-1:0]       rom_type,
	input  logic [rom_addr_w-1:0]   rom_mask,
	input  logic [bsram_addr_w-1:0] ram_mask,

	input  logic [cpu_addr_w-1:0]   cpu_addr,
	input  logic [data_w-1:0]       cpu_wdata,
	input  logic                    cpu_rd,
	input  logic                    cpu_wr,
	output logic [data_w-1:0]       cpu_rdata,
	output logic                    cpu_rdata_valid,

	output logic [rom_addr_w-1:0]   rom_addr,
	output logic                    rom_ce_n,
	output logic                    rom_oe_n,
	input  logic [rom_data_w-1:0]   rom_q,

	output logic [bsram_addr_w-1:0] bsram_addr,
	output logic [data_w-1:0]       bsram_d,
	output logic                    bsram_ce_n,
	output logic                    bsram_oe_n,
	output logic                    bsram_we_n,
	input  logic [data_w-1:0]       bsram_q,

	output logic [15:0]             track_num,
	output logic                    track_request,
	input  logic                    track_mounting,
	input  logic                    track_missing,
	output logic [data_w-1:0]       volume,
	output logic                    audio_repeat,
	output logic                    audio_playing
);

	access_t                 access;
	logic [rom_addr_w-1:0]   rom_addr_next;
	logic [bsram_addr_w-1:0] bsram_addr_next;
	access_t                 stage_access;
	logic                    stage_rd;
	logic                    stage_hi_byte;
	logic [data_w-1:0]       msu_rdata;

	////////////////////////////////////////
	// Decode
	////////////////////////////////////////

	map_decode map_decode_i (
		.rom_type        (rom_type),
		.cpu_addr        (cpu_addr),
		.rom_mask        (rom_mask),
		.ram_mask        (ram_mask),
		.access          (access),
		.rom_addr_next   (rom_addr_next),
		.bsram_addr_next (bsram_addr_next)
	);

	////////////////////////////////////////
	// Execute
	////////////////////////////////////////

	rom_map rom_map_i (
		.mclk            (mclk),
		.reset           (reset),
		.cpu_rd          (cpu_rd),
		.cpu_wr          (cpu_wr),
		.cpu_wdata       (cpu_wdata),
		.access          (access),
		.rom_addr_next   (rom_addr_next),
		.bsram_addr_next (bsram_addr_next),
		.rom_addr        (rom_addr),
		.rom_ce_n        (rom_ce_n),
		.rom_oe_n        (rom_oe_n),
		.bsram_addr      (bsram_addr),
		.bsram_d         (bsram_d),
		.bsram_ce_n      (bsram_ce_n),
		.bsram_oe_n      (bsram_oe_n),
		.bsram_we_n      (bsram_we_n),
		.stage_access    (stage_access),
		.stage_rd        (stage_rd),
		.stage_hi_byte   (stage_hi_byte)
	);

	msu_regs msu_regs_i (
		.mclk           (mclk),
		.reset          (reset),
		.cpu_rd         (cpu_rd),
		.cpu_wr         (cpu_wr),
		.cpu_wdata      (cpu_wdata),
		.cpu_addr       (cpu_addr),
		.access         (access),
		.track_mounting (track_mounting),
		.track_missing  (track_missing),
		.msu_rdata      (msu_rdata),
		.track_num      (track_num),
		.track_request  (track_request),
		.volume         (volume),
		.audio_repeat   (audio_repeat),
		.audio_playing  (audio_playing)
	);

	////////////////////////////////////////
	// Result
	////////////////////////////////////////

	read_mux read_mux_i (
		.mclk            (mclk),
		.reset           (reset),
		.stage_access    (stage_access),
		.stage_rd        (stage_rd),
		.stage_hi_byte   (stage_hi_byte),
		.rom_q           (rom_q),
		.bsram_q         (bsram_q),
		.msu_rdata       (msu_rdata),
		.cpu_rdata       (cpu_rdata),
		.cpu_rdata_valid (cpu_rdata_valid)
	);

endmodule

`default_nettype wire

// ==== cart_bus_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module cart_bus_checker (
	input logic mclk,
	input logic reset,
	input logic rom_ce_n,
	input logic rom_oe_n,
	input logic bsram_ce_n,
	input logic bsram_oe_n,
	input logic bsram_we_n,
	input logic stage_rd
);

	// ROM and save RAM share the cartridge bus, so only one chip is enabled.
	ce_exclusive: assert property (@(posedge mclk) disable iff (reset) rom_ce_n || bsram_ce_n)
		else $error("rom_ce_n and bsram_ce_n are low in the same cycle");

	oe_we_exclusive: assert property (@(posedge mclk) disable iff (reset)
		bsram_oe_n || bsram_we_n)
		else $error("bsram_oe_n and bsram_we_n are low in the same cycle");

	reset_idle: assert property (@(posedge mclk)
		reset |=> rom_ce_n && rom_oe_n && bsram_ce_n && bsram_oe_n && bsram_we_n && !stage_rd)
		else $error("memory strobes are not idle after a reset cycle");

endmodule

bind rom_map cart_bus_checker cart_bus_checker_i (
	.mclk       (mclk),
	.reset      (reset),
	.rom_ce_n   (rom_ce_n),
	.rom_oe_n   (rom_oe_n),
	.bsram_ce_n (bsram_ce_n),
	.bsram_oe_n (bsram_oe_n),
	.bsram_we_n (bsram_we_n),
	.stage_rd   (stage_rd)
);

`default_nettype wire

// ==== cart_bus_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cart_bus_tb import cart_pkg::*; ();

	localparam int period_ns     = 4;
	localparam int total_strobes = 120;
	localparam int margin_ns     = 400;
	localparam logic [47:0] msu_id = "S-MSU1";

	logic                    mclk = 1'b0;
	logic                    reset;
	logic [data_w-1:0]       rom_type;
	logic [rom_addr_w-1:0]   rom_mask;
	logic [bsram_addr_w-1:0] ram_mask;
	logic [cpu_addr_w-1:0]   cpu_addr;
	logic [data_w-1:0]       cpu_wdata;
	logic                    cpu_rd;
	logic                    cpu_wr;
	logic [data_w-1:0]       cpu_rdata;
	logic                    cpu_rdata_valid;
	logic [rom_addr_w-1:0]   rom_addr;
	logic                    rom_ce_n;
	logic                    rom_oe_n;
	logic [rom_data_w-1:0]   rom_q;
	logic [bsram_addr_w-1:0] bsram_addr;
	logic [data_w-1:0]       bsram_d;
	logic                    bsram_ce_n;
	logic                    bsram_oe_n;
	logic                    bsram_we_n;
	logic [data_w-1:0]       bsram_q;
	logic [15:0]             track_num;
	logic                    track_request;
	logic                    track_mounting;
	logic                    track_missing;
	logic [data_w-1:0]       volume;
	logic                    audio_repeat;
	logic                    audio_playing;

	integer      seed = 32'h0b40_5328;
	int          edge_cnt = 0;
	int          data_errors = 0;
	int          latency_errors = 0;
	int          stray_pulses = 0;
	int          check_errors = 0;
	int          request_pulses = 0;
	logic [7:0]  last_expected = 8'h00;
	logic [15:0] exp_track = 16'h0000;
	logic [7:0]  exp_volume = 8'h00;
	logic        exp_playing = 1'b0;
	logic        exp_repeat = 1'b0;

	logic [7:0]  bsram_mem [0:(1 << bsram_addr_w) - 1];
	logic [7:0]  bsram_shadow [logic [19:0]];
	logic [7:0]  exp_data_q [$];
	int          due_q [$];
	string       name_q [$];

	cart_bus cart_bus_i (.*);

	always #(period_ns / 2) mclk = ~mclk;

	always @(posedge mclk) begin
		edge_cnt <= edge_cnt + 1;
	end

	////////////////////////////////////////
	// Memory models
	////////////////////////////////////////

	function automatic logic [7:0] rom_fill(input logic [23:0] a);
		return a[7:0] ^ {a[14:8], a[15]} ^ a[23:16] ^ 8'ha5;
	endfunction

	function automatic logic [7:0] bsram_fill(input logic [19:0] a);
		return a[7:0] ^ a[15:8] ^ {a[11:8], a[19:16]} ^ 8'h3c;
	endfunction

	// The chips drive their data only while enabled.
	assign rom_q   = (!rom_ce_n && !rom_oe_n) ?
		{rom_fill(rom_addr | 24'h000001), rom_fill(rom_addr & 24'hfffffe)} : 'x;
	assign bsram_q = (!bsram_ce_n && !bsram_oe_n) ? bsram_mem[bsram_addr] : 'x;

	always @(posedge mclk) begin
		if (!bsram_ce_n && !bsram_we_n) begin
			bsram_mem[bsram_addr] <= bsram_d;
		end
	end

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	function automatic access_t classify(input logic [23:0] addr, output logic [23:0] mapped);
		logic [7:0]  bank;
		logic [15:0] off;
		bank   = addr[23:16];
		off    = addr[15:0];
		mapped = 24'h000000;
		if (bank == 8'h7e || bank == 8'h7f) begin
			return acc_none;
		end
		if (!bank[6] && off >= 16'h2000 && off <= 16'h2007) begin
			mapped = {21'h000000, off[2:0]};
			return acc_msu;
		end
		if (rom_type[0]) begin
			if (bank[6] || off[15]) begin
				mapped = {2'b00, bank[5:0], off} & rom_mask;
				return acc_rom;
			end
			if (bank[6:5] == 2'b01 && off[15:13] == 3'b011) begin
				mapped = {6'h00, bank[4:0], off[12:0]} & {4'h0, ram_mask};
				return acc_bsram;
			end
		end else begin
			if (off[15]) begin
				mapped = {2'b00, bank[6:0], off[14:0]} & rom_mask;
				return acc_rom;
			end
			if (bank >= 8'h70 && bank <= 8'h7d) begin
				mapped = {5'h00, bank[3:0], off[14:0]} & {4'h0, ram_mask};
				return acc_bsram;
			end
		end
		return acc_none;
	endfunction

	function automatic logic [7:0] msu_byte(input logic [2:0] sel);
		int idx;
		if (sel == 3'd0) begin
			return {track_mounting, track_missing, exp_playing, exp_repeat, 4'h0};
		end
		if (sel == 3'd7) begin
			return 8'h00;
		end
		idx = 6 - int'(sel); // First identity character sits in the top byte.
		return msu_id[idx * 8 +: 8];
	endfunction

	function automatic logic [7:0] expected_read(input logic [23:0] addr, input logic [7:0] last);
		logic [23:0] mapped;
		access_t     cls;
		cls = classify(addr, mapped);
		case (cls)
		acc_rom:   return rom_fill(mapped);
		acc_bsram: return bsram_shadow.exists(mapped[19:0]) ?
			bsram_shadow[mapped[19:0]] : bsram_fill(mapped[19:0]);
		acc_msu:   return msu_byte(mapped[2:0]);
		default:   return last; // Open bus.
		endcase
	endfunction

	////////////////////////////////////////
	// Stimulus tasks
	////////////////////////////////////////

	function automatic logic [31:0] random_word();
		logic [31:0] r;
		r = $random(seed);
		return r;
	endfunction

	task automatic idle(input int cycles);
		repeat (cycles) begin
			@(posedge mclk);
			cpu_rd <= 1'b0;
			cpu_wr <= 1'b0;
		end
	endtask

	task automatic issue_read(input logic [23:0] addr, input string name);
		logic [7:0] exp;
		@(posedge mclk);
		exp           = expected_read(addr, last_expected);
		last_expected = exp;
		exp_data_q.push_back(exp);
		due_q.push_back(edge_cnt + 3); // Data is registered one edge after the sampling edge.
		name_q.push_back(name);
		cpu_addr <= addr;
		cpu_rd   <= 1'b1;
		cpu_wr   <= 1'b0;
	endtask

	task automatic issue_write(input logic [23:0] addr, input logic [7:0] data);
		logic [23:0] mapped;
		access_t     cls;
		@(posedge mclk);
		cls = classify(addr, mapped);
		if (cls == acc_bsram) begin
			bsram_shadow[mapped[19:0]] = data;
		end
		if (cls == acc_msu) begin
			case (mapped[2:0])
			3'd4: exp_track[7:0] = data;
			3'd5: exp_track[15:8] = data;
			3'd6: exp_volume = data;
			3'd7: begin
				exp_playing = data[0];
				exp_repeat  = data[1];
			end
			default: begin
			end
			endcase
		end
		cpu_addr  <= addr;
		cpu_wdata <= data;
		cpu_wr    <= 1'b1;
		cpu_rd    <= 1'b0;
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			check_errors++;
			$display("Mismatch %s: expected %h actual %h", name, exp, act);
		end
	endtask

	////////////////////////////////////////
	// Compare and watchdog
	////////////////////////////////////////

	always @(negedge mclk) begin
		if (!reset && cpu_rdata_valid) begin
			if (exp_data_q.size() == 0) begin
				stray_pulses++;
				$display("cpu_rdata_valid pulsed with no read outstanding");
			end else begin
				if (edge_cnt != due_q[0]) begin
					latency_errors++;
					$display("Mismatch %s latency: expected edge %0d actual edge %0d",
						name_q[0], due_q[0], edge_cnt);
				end
				if (cpu_rdata !== exp_data_q[0]) begin
					data_errors++;
					$display("Mismatch %s: expected %h actual %h",
						name_q[0], exp_data_q[0], cpu_rdata);
				end
				void'(exp_data_q.pop_front());
				void'(due_q.pop_front());
				void'(name_q.pop_front());
			end
		end
		if (!reset && track_request) begin
			request_pulses++;
		end
	end

	// Each strobe takes at most two cycles including its gap.
	initial begin
		#(total_strobes * 2 * period_ns + margin_ns);
		$display("Watchdog expired with %0d reads outstanding", exp_data_q.size());
		$display("FAIL: see errors above");
		$finish;
	end

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial begin
		logic [23:0] a;
		logic [31:0] r;
		logic [23:0] saved [8];
		int          pulses_before;
		reset          = 1'b1;
		rom_type       = 8'h00;
		rom_mask       = 24'hffffff;
		ram_mask       = 20'hfffff;
		cpu_addr       = 24'h000000;
		cpu_wdata      = 8'h00;
		cpu_rd         = 1'b0;
		cpu_wr         = 1'b0;
		track_mounting = 1'b0;
		track_missing  = 1'b0;
		for (int k = 0; k < (1 << bsram_addr_w); k++) begin
			bsram_mem[k] = bsram_fill(k[19:0]);
		end
		repeat (5) @(posedge mclk);
		reset <= 1'b0;
		@(negedge mclk);
		check_value("reset_state", 32'h7c, 32'({rom_ce_n, rom_oe_n, bsram_ce_n, bsram_oe_n,
			bsram_we_n, cpu_rdata_valid, track_request}));

		for (int i = 0; i < 40; i++) begin
			r = random_word();
			a = r[23:0];
			a[15] = 1'b1;
			if (a[23:17] == 7'h3f) begin
				a[23] = 1'b1; // Keep clear of the WRAM banks.
			end
			issue_read(a, "lorom_read");
			if (a[9]) begin
				idle(1);
			end
		end
		idle(4);

		rom_type <= 8'h01;
		rom_mask <= 24'h0fffff;
		idle(1);
		for (int i = 0; i < 30; i++) begin
			r = random_word();
			a = r[23:0];
			if (!a[22]) begin
				a[15] = 1'b1; // Low banks hold ROM in their upper half.
			end
			if (a[23:17] == 7'h3f) begin
				a[23] = 1'b1;
			end
			issue_read(a, "hirom_masked_read");
			if (a[9]) begin
				idle(1);
			end
		end
		idle(4);

		rom_type <= 8'h00;
		ram_mask <= 20'h1ffff;
		idle(1);
		for (int i = 0; i < 8; i++) begin
			r = random_word();
			saved[i] = {8'h70 | {5'h00, r[18:16]}, 1'b0, r[14:0]};
			issue_write(saved[i], r[31:24]);
		end
		for (int i = 0; i < 8; i++) begin
			issue_read(saved[i], "lorom_bsram");
		end
		idle(4);

		rom_type <= 8'h01;
		ram_mask <= 20'h07fff;
		idle(1);
		for (int i = 0; i < 8; i++) begin
			r = random_word();
			saved[i] = {r[23], 2'b01, r[20:16], 3'b011, r[12:0]};
			issue_write(saved[i], r[31:24]);
		end
		for (int i = 0; i < 8; i++) begin
			issue_read(saved[i], "hirom_bsram");
		end
		idle(4);

		rom_type <= 8'h00;
		pulses_before = request_pulses;
		issue_write(24'h002004, 8'h34);
		issue_write(24'h802005, 8'h12);
		issue_write(24'h002006, 8'h80);
		issue_write(24'h002007, 8'h01);
		idle(3);
		@(negedge mclk);
		check_value("track_request_pulses", 32'(pulses_before + 1), 32'(request_pulses));
		check_value("track_num", 32'(exp_track), 32'(track_num));
		check_value("volume", 32'(exp_volume), 32'(volume));
		check_value("audio_playing", 32'(exp_playing), 32'(audio_playing));
		check_value("audio_repeat", 32'(exp_repeat), 32'(audio_repeat));
		idle(1);
		track_mounting <= 1'b1;
		for (int i = 0; i < 8; i++) begin
			issue_read(24'h002000 | 24'(i), "msu_read");
		end
		track_mounting <= 1'b0;
		track_missing  <= 1'b1;
		issue_write(24'h002007, 8'h02);
		issue_read(24'h002000, "msu_status");
		idle(4);
		@(negedge mclk);
		check_value("audio_playing", 32'(exp_playing), 32'(audio_playing));
		check_value("audio_repeat", 32'(exp_repeat), 32'(audio_repeat));

		issue_read(24'h01c123, "open_bus_seed");
		issue_read(24'h7e1234, "open_bus_7e");
		issue_read(24'h7fffff, "open_bus_7f");
		idle(4);
		@(negedge mclk);
		check_value("reads_outstanding", 32'h0, 32'(exp_data_q.size()));

		$display("Errors: %0d data, %0d latency, %0d stray pulses, %0d other",
			data_errors, latency_errors, stray_pulses, check_errors);
		if (data_errors + latency_errors + stray_pulses + check_errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== cart_pkg.sv ====
`default_nettype none

package cart_pkg;

	////////////////////////////////////////
	// Bus widths
	////////////////////////////////////////

	localparam int cpu_addr_w   = 24;
	localparam int rom_addr_w   = 24;
	localparam int bsram_addr_w = 20;
	localparam int data_w       = 8;
	localparam int rom_data_w   = 16; // Low byte at even addresses, high byte at odd.

	////////////////////////////////////////
	// Memory map constants
	////////////////////////////////////////

	localparam logic [7:0]  wram_bank_lo    = 8'h7e; // Console WRAM, never mapped here.
	localparam logic [7:0]  wram_bank_hi    = 8'h7f;
	localparam logic [15:0] msu_base        = 16'h2000; // Window is 2000..2007.
	localparam logic [7:0]  lorom_sram_bank = 8'h70; // LoROM save RAM runs from bank 70 to 7D.

	// Class of a CPU access as seen by the cartridge.
	typedef enum logic [1:0] {
		acc_none,
		acc_rom,
		acc_bsram,
		acc_msu
	} access_t;

	// LoROM splits the bank offset at a15.
	typedef struct packed {
		logic [7:0]  bank;
		logic        a15;
		logic [14:0] offset;
	} lorom_view_t;

	// HiROM uses the whole 16-bit bank offset.
	typedef struct packed {
		logic [7:0]  bank;
		logic [15:0] offset;
	} hirom_view_t;

	typedef union packed {
		lorom_view_t lo;
		hirom_view_t hi;
	} cpu_addr_u;

endpackage

`default_nettype wire

// ==== files.f ====
cart_pkg.sv
map_decode.sv
rom_map.sv
msu_regs.sv
read_mux.sv
cart_bus.sv
cart_bus_checker.sv
cart_bus_tb.sv

// ==== map_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module map_decode import cart_pkg::*; (
	input  logic [data_w-1:0]       rom_type,
	input  cpu_addr_u               cpu_addr,
	input  logic [rom_addr_w-1:0]   rom_mask,
	input  logic [bsram_addr_w-1:0] ram_mask,
	output access_t                 access,
	output logic [rom_addr_w-1:0]   rom_addr_next,
	output logic [bsram_addr_w-1:0] bsram_addr_next
);

	logic                    hirom;
	logic [7:0]              bank;
	logic                    is_wram;
	logic                    is_msu;
	logic                    lo_rom;
	logic                    lo_sram;
	logic                    hi_rom;
	logic                    hi_sram;
	logic [rom_addr_w-1:0]   lo_rom_addr;
	logic [rom_addr_w-1:0]   hi_rom_addr;
	logic [bsram_addr_w-1:0] lo_sram_addr;
	logic [bsram_addr_w-1:0] hi_sram_addr;

	assign hirom = rom_type[0];
	assign bank  = cpu_addr.hi.bank;

	assign is_wram = (bank == wram_bank_lo) || (bank == wram_bank_hi);
	assign is_msu  = !bank[6] && (cpu_addr.hi.offset[15:3] == msu_base[15:3]);

	////////////////////////////////////////
	// LoROM
	////////////////////////////////////////

	assign lo_rom  = cpu_addr.lo.a15;
	assign lo_sram = !cpu_addr.lo.a15 && (bank[7:4] == lorom_sram_bank[7:4]); // 7E/7F go first.

	assign lo_rom_addr  = {2'b00, bank[6:0], cpu_addr.lo.offset};
	assign lo_sram_addr = {1'b0, bank[3:0], cpu_addr.lo.offset};

	////////////////////////////////////////
	// HiROM
	////////////////////////////////////////

	assign hi_rom  = bank[6] || cpu_addr.hi.offset[15];
	assign hi_sram = (bank[6:5] == 2'b01) && (cpu_addr.hi.offset[15:13] == 3'b011);

	assign hi_rom_addr  = {2'b00, bank[5:0], cpu_addr.hi.offset};
	assign hi_sram_addr = {2'b00, bank[4:0], cpu_addr.hi.offset[12:0]};

	// The register window wins over both mappers.
	always_comb begin
		access          = acc_none;
		rom_addr_next   = (hirom ? hi_rom_addr : lo_rom_addr) & rom_mask;
		bsram_addr_next = (hirom ? hi_sram_addr : lo_sram_addr) & ram_mask;

		if (is_wram) begin
			access = acc_none;
		end else if (is_msu) begin
			access = acc_msu;
		end else if (hirom ? hi_rom : lo_rom) begin
			access = acc_rom;
		end else if (hirom ? hi_sram : lo_sram) begin
			access = acc_bsram;
		end
	end

endmodule

`default_nettype wire

// ==== msu_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module msu_regs import cart_pkg::*; (
	input  logic              mclk,
	input  logic              reset,

	input  logic              cpu_rd,
	input  logic              cpu_wr,
	input  logic [data_w-1:0] cpu_wdata,
	input  cpu_addr_u         cpu_addr,
	input  access_t           access,

	input  logic              track_mounting,
	input  logic              track_missing,

	output logic [data_w-1:0] msu_rdata,
	output logic [15:0]       track_num,
	output logic              track_request,
	output logic [data_w-1:0] volume,
	output logic              audio_repeat,
	output logic              audio_playing
);

	logic [2:0]        reg_sel;
	logic              msu_wr;
	logic              msu_rd;
	logic [data_w-1:0] rd_byte;

	assign reg_sel = cpu_addr.hi.offset[2:0];
	assign msu_wr  = cpu_wr && (access == acc_msu);
	assign msu_rd  = cpu_rd && (access == acc_msu);

	////////////////////////////////////////
	// Register writes
	////////////////////////////////////////

	always_ff @(posedge mclk) begin
		if (reset) begin
			track_num     <= '0;
			track_request <= 1'b0;
			volume        <= '0;
			audio_repeat  <= 1'b0;
			audio_playing <= 1'b0;
		end else begin
			track_request <= 1'b0;
			if (msu_wr) begin
				case (reg_sel)
				3'd4: track_num[7:0] <= cpu_wdata;
				3'd5: begin
					track_num[15:8] <= cpu_wdata;
					track_request   <= 1'b1; // High byte completes the track number.
				end
				3'd6: volume <= cpu_wdata;
				3'd7: begin
					audio_playing <= cpu_wdata[0];
					audio_repeat  <= cpu_wdata[1];
				end
				default: begin
				end
				endcase
			end
		end
	end

	////////////////////////////////////////
	// Status and identity reads
	////////////////////////////////////////

	always_comb begin
		case (reg_sel)
		3'd0: rd_byte = {track_mounting, track_missing, audio_playing, audio_repeat, 4'h0};
		3'd1: rd_byte = "S";
		3'd2: rd_byte = "-";
		3'd3: rd_byte = "M";
		3'd4: rd_byte = "S";
		3'd5: rd_byte = "U";
		3'd6: rd_byte = "1";
		default: rd_byte = 8'h00;
		endcase
	end

	always_ff @(posedge mclk) begin
		if (msu_rd) begin
			msu_rdata <= rd_byte;
		end
	end

endmodule

`default_nettype wire

// ==== read_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module read_mux import cart_pkg::*; (
	input  logic                  mclk,
	input  logic                  reset,

	input  access_t               stage_access,
	input  logic                  stage_rd,
	input  logic                  stage_hi_byte,

	input  logic [rom_data_w-1:0] rom_q,
	input  logic [data_w-1:0]     bsram_q,
	input  logic [data_w-1:0]     msu_rdata,

	output logic [data_w-1:0]     cpu_rdata,
	output logic                  cpu_rdata_valid
);

	logic [data_w-1:0] rom_byte;
	logic [data_w-1:0] rdata_next;

	assign rom_byte = stage_hi_byte ? rom_q[rom_data_w-1:data_w] : rom_q[data_w-1:0];

	always_comb begin
		case (stage_access)
		acc_msu:   rdata_next = msu_rdata;
		acc_bsram: rdata_next = bsram_q;
		acc_rom:   rdata_next = rom_byte;
		default:   rdata_next = cpu_rdata; // Open bus repeats the last byte.
		endcase
	end

	// cpu_rdata doubles as the open-bus latch, so it only moves on reads.
	always_ff @(posedge mclk) begin
		if (reset) begin
			cpu_rdata       <= '0;
			cpu_rdata_valid <= 1'b0;
		end else begin
			cpu_rdata_valid <= stage_rd;
			if (stage_rd) begin
				cpu_rdata <= rdata_next;
			end
		end
	end

endmodule

`default_nettype wire

// ==== rom_map.sv ====
`timescale 1ns/1ps
`default_nettype none

module rom_map import cart_pkg::*; (
	input  logic                    mclk,
	input  logic                    reset,

	input  logic                    cpu_rd,
	input  logic                    cpu_wr,
	input  logic [data_w-1:0]       cpu_wdata,

	input  access_t                 access,
	input  logic [rom_addr_w-1:0]   rom_addr_next,
	input  logic [bsram_addr_w-1:0] bsram_addr_next,

	output logic [rom_addr_w-1:0]   rom_addr,
	output logic                    rom_ce_n,
	output logic                    rom_oe_n,

	output logic [bsram_addr_w-1:0] bsram_addr,
	output logic [data_w-1:0]       bsram_d,
	output logic                    bsram_ce_n,
	output logic                    bsram_oe_n,
	output logic                    bsram_we_n,

	output access_t                 stage_access,
	output logic                    stage_rd,
	output logic                    stage_hi_byte
);

	logic rom_hit;
	logic bsram_hit;

	assign rom_hit   = cpu_rd && (access == acc_rom); // ROM ignores writes.
	assign bsram_hit = (cpu_rd || cpu_wr) && (access == acc_bsram);

	// Each strobe is low for the single cycle after its access.
	always_ff @(posedge mclk) begin
		if (reset) begin
			rom_ce_n   <= 1'b1;
			rom_oe_n   <= 1'b1;
			bsram_ce_n <= 1'b1;
			bsram_oe_n <= 1'b1;
			bsram_we_n <= 1'b1;
		end else begin
			rom_ce_n   <= !rom_hit;
			rom_oe_n   <= !rom_hit;
			bsram_ce_n <= !bsram_hit;
			bsram_oe_n <= !(bsram_hit && cpu_rd);
			bsram_we_n <= !(bsram_hit && cpu_wr);
		end
	end

	always_ff @(posedge mclk) begin
		if (rom_hit) begin
			rom_addr <= rom_addr_next;
		end
		if (bsram_hit) begin
			bsram_addr <= bsram_addr_next;
			bsram_d    <= cpu_wdata;
		end
	end

	// Stage one of the read path, consumed by the data mux.
	always_ff @(posedge mclk) begin
		if (reset) begin
			stage_access <= acc_none;
			stage_rd     <= 1'b0;
		end else begin
			stage_access <= (cpu_rd || cpu_wr) ? access : acc_none;
			stage_rd     <= cpu_rd;
		end
	end

	always_ff @(posedge mclk) begin
		stage_hi_byte <= rom_addr_next[0]; // Picks the byte lane of the ROM word.
	end

endmodule

`default_nettype wire
